// ==== rtl/sweep_defs.svh ====
`ifndef SWEEP_DEFS_SVH
`define SWEEP_DEFS_SVH

// Datapath widths
`define DAC_WIDTH        10
`define WORD_WIDTH       16

// Event size and buffering
`define WORDS_PER_EVENT  10
`define HIT_FIFO_DEPTH   32
`define OUT_FIFO_DEPTH   8

// Cycles to wait after the ASIC latch before acquiring
`define SETTLE_CYCLES    40

// Link credits available after reset
`define CREDIT_MAX       4

// Stream framing words
`define HEADER_WORD      16'h5341
`define TAIL_WORD        16'hFF45
// Top nibble of a step marker
`define STEP_TAG         4'hD

`endif

// ==== rtl/sweep_pkg.sv ====
`include "sweep_defs.svh"

package sweep_pkg;

    // Threshold DAC code
    typedef logic [`DAC_WIDTH-1:0] DacCode_t;

    // Sweep controller states
    typedef enum logic [2:0] {
        stIdle,
        stHeader,
        stMarker,
        stLoad,
        stWaitCfg,
        stAcquire,
        stCopy,
        stTail
    } SweepState_t;

endpackage

// ==== rtl/daq_pkg.sv ====
`include "sweep_defs.svh"

package daq_pkg;

    // One front-end hit word
    typedef logic [`WORD_WIDTH-1:0] HitWord_t;

    // Output queue entry, word plus end-of-stream flag
    typedef struct packed {
        HitWord_t Word;
        logic     Last;
    } OutEntry_t;

endpackage

// ==== rtl/syncFifo.sv ====
`timescale 1ns/100ps

module syncFifo #(
    parameter type Payload_t = logic [15:0],
    parameter int  Depth     = 8
) (
    input  logic     Clk,
    input  logic     reset_n,
    input  logic     Push,
    input  Payload_t PushData,
    input  logic     Pop,
    output Payload_t PopData,
    output logic     Empty,
    output logic     Full
);
    localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CntWidth = $clog2(Depth + 1);

    Payload_t            mem [Depth];
    logic [PtrWidth-1:0] wrPtr;
    logic [PtrWidth-1:0] rdPtr;
    logic [CntWidth-1:0] count;
    logic                doPush;
    logic                doPop;

    // Pointer advance with wrap for any depth
    function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
        return (ptr == PtrWidth'(Depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign doPush  = Push && !Full;
    assign doPop   = Pop && !Empty;
    assign Empty   = (count == '0);
    assign Full    = (count == CntWidth'(Depth));
    assign PopData = mem[rdPtr];

    always_ff @(posedge Clk) begin
        if (doPush) begin
            mem[wrPtr] <= PushData;
        end
    end

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (doPop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== rtl/eventFramer.sv ====
`timescale 1ns/100ps
`include "sweep_defs.svh"

module eventFramer (
    input  logic              Clk,
    input  logic              reset_n,
    input  daq_pkg::HitWord_t HitData,
    input  logic              HitValid,
    input  logic              AcqEnable,
    output logic              FifoPush,
    output daq_pkg::HitWord_t FifoData,
    output logic              EventReady
);
    localparam int CntWidth = ($clog2(`WORDS_PER_EVENT) > 0) ? $clog2(`WORDS_PER_EVENT) : 1;

    logic [CntWidth-1:0] wordCnt;
    logic                lastWord;

    // Words only enter the hit FIFO inside the acquisition window
    assign FifoPush = HitValid && AcqEnable;
    assign FifoData = HitData;
    assign lastWord = (wordCnt == CntWidth'(`WORDS_PER_EVENT - 1));

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            wordCnt    <= '0;
            EventReady <= 1'b0;
        end else if (!AcqEnable) begin
            // Drop any partial event between steps
            wordCnt    <= '0;
            EventReady <= 1'b0;
        end else begin
            EventReady <= FifoPush && lastWord;
            if (FifoPush) begin
                wordCnt <= lastWord ? '0 : wordCnt + 1'b1;
            end
        end
    end

endmodule

// ==== rtl/scConfigLoader.sv ====
`timescale 1ns/100ps
`include "sweep_defs.svh"

module scConfigLoader (
    input  logic                Clk,
    input  logic                reset_n,
    input  logic                LoadDac,
    input  sweep_pkg::DacCode_t DacCode,
    output logic                ScData,
    output logic                ScShift,
    output logic                ScLatch,
    output logic                ConfigDone
);
    import sweep_pkg::*;

    localparam int BitCntWidth    = $clog2(`DAC_WIDTH);
    localparam int SettleCntWidth = $clog2(`SETTLE_CYCLES);

    DacCode_t                  shiftReg;
    logic [BitCntWidth-1:0]    bitCnt;
    logic [SettleCntWidth-1:0] settleCnt;
    logic                      settling;

    // ASIC expects LSB of the code first, so the register holds it reversed
    assign ScData = shiftReg[`DAC_WIDTH-1];

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            shiftReg   <= '0;
            bitCnt     <= '0;
            settleCnt  <= '0;
            settling   <= 1'b0;
            ScShift    <= 1'b0;
            ScLatch    <= 1'b0;
            ConfigDone <= 1'b0;
        end else begin
            ScLatch    <= 1'b0;
            ConfigDone <= 1'b0;
            if (LoadDac) begin
                shiftReg <= {<<{DacCode}};
                bitCnt   <= '0;
                settling <= 1'b0;
                ScShift  <= 1'b1;
            end else if (ScShift) begin
                shiftReg <= shiftReg << 1;
                bitCnt   <= bitCnt + 1'b1;
                if (bitCnt == BitCntWidth'(`DAC_WIDTH - 1)) begin
                    ScShift <= 1'b0;
                    ScLatch <= 1'b1;
                end
            end else if (ScLatch) begin
                settling  <= 1'b1;
                settleCnt <= SettleCntWidth'(1);
            end else if (settling) begin
                // Settle count runs from the latch cycle
                if (settleCnt == SettleCntWidth'(`SETTLE_CYCLES - 1)) begin
                    settling   <= 1'b0;
                    ConfigDone <= 1'b1;
                end else begin
                    settleCnt <= settleCnt + 1'b1;
                end
            end
        end
    end

endmodule

// ==== rtl/creditSender.sv ====
`timescale 1ns/100ps
`include "sweep_defs.svh"

module creditSender (
    input  logic                   Clk,
    input  logic                   reset_n,
    input  daq_pkg::OutEntry_t     QueueData,
    input  logic                   QueueEmpty,
    output logic                   QueuePop,
    input  logic                   CreditReturn,
    output logic [`WORD_WIDTH-1:0] OutData,
    output logic                   OutValid,
    output logic                   OutLast
);
    localparam int CreditWidth = $clog2(`CREDIT_MAX + 1);

    logic [CreditWidth-1:0] credits;

    // One word per cycle while the link has room
    assign QueuePop = !QueueEmpty && (credits != '0);

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            credits <= CreditWidth'(`CREDIT_MAX);
        end else begin
            case ({QueuePop, CreditReturn})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            OutValid <= 1'b0;
            OutLast  <= 1'b0;
        end else begin
            OutValid <= QueuePop;
            OutLast  <= QueuePop && QueueData.Last;
        end
    end

    always_ff @(posedge Clk) begin
        if (QueuePop) begin
            OutData <= QueueData.Word;
        end
    end

endmodule

// ==== rtl/sweepControl.sv ====
`timescale 1ns/100ps
`include "sweep_defs.svh"

module sweepControl (
    input  logic                Clk,
    input  logic                reset_n,
    input  logic                SweepStart,
    input  sweep_pkg::DacCode_t StartDac,
    input  sweep_pkg::DacCode_t EndDac,
    input  logic [15:0]         EventsPerStep,
    // Slow-control loader
    output logic                LoadDac,
    output sweep_pkg::DacCode_t DacCode,
    input  logic                ConfigDone,
    // Front end
    output logic                AcqEnable,
    input  logic                EventReady,
    // Hit FIFO
    output logic                HitPop,
    input  daq_pkg::HitWord_t   HitData,
    // Output queue
    output logic                OutPush,
    output daq_pkg::OutEntry_t  OutEntry,
    input  logic                OutFull,
    // Status
    output logic                StepDone,
    output logic                SweepBusy
);
    import sweep_pkg::*;

    localparam int WordCntWidth =
        ($clog2(`WORDS_PER_EVENT) > 0) ? $clog2(`WORDS_PER_EVENT) : 1;

    SweepState_t             state;
    DacCode_t                curDac;
    DacCode_t                lastDac;
    logic [15:0]             evTarget;
    logic [15:0]             evReceived;
    logic [15:0]             pending;
    logic [WordCntWidth-1:0] wordCnt;
    logic                    queueOk;
    logic                    wordLast;
    logic                    eventCopied;
    logic                    stepComplete;
    logic                    lastEventIn;

    ////////////////////////////////////////////////////////////
    // Status and handshakes
    ////////////////////////////////////////////////////////////
    assign queueOk      = !OutFull;
    assign wordLast     = (wordCnt == WordCntWidth'(`WORDS_PER_EVENT - 1));
    assign eventCopied  = (state == stCopy) && queueOk && wordLast;
    assign stepComplete = eventCopied && (evReceived == evTarget) && (pending == 16'd1);
    assign lastEventIn  = EventReady && (evReceived + 16'd1 == evTarget);

    // Window closes on the final event so no stray words reach the hit FIFO
    assign AcqEnable = ((state == stAcquire) || (state == stCopy))
                       && (evReceived != evTarget) && !lastEventIn;

    assign LoadDac   = (state == stLoad);
    assign DacCode   = curDac;
    assign HitPop    = (state == stCopy) && queueOk;
    assign SweepBusy = (state != stIdle);

    always_comb begin
        OutPush       = 1'b0;
        OutEntry.Word = HitData;
        OutEntry.Last = 1'b0;
        case (state)
            stHeader: begin
                OutPush       = queueOk;
                OutEntry.Word = `HEADER_WORD;
            end
            stMarker: begin
                OutPush       = queueOk;
                OutEntry.Word = {`STEP_TAG, 2'b00, curDac};
            end
            stCopy: OutPush = queueOk;
            stTail: begin
                OutPush       = queueOk;
                OutEntry.Word = `TAIL_WORD;
                OutEntry.Last = 1'b1;
            end
            default: OutPush = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Sweep FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            state      <= stIdle;
            curDac     <= '0;
            lastDac    <= '0;
            evTarget   <= 16'd1;
            evReceived <= '0;
            pending    <= '0;
            wordCnt    <= '0;
            StepDone   <= 1'b0;
        end else begin
            StepDone <= 1'b0;
            // Pending events in the hit FIFO
            if (EventReady && !eventCopied) begin
                pending <= pending + 16'd1;
            end else if (!EventReady && eventCopied) begin
                pending <= pending - 16'd1;
            end
            if (EventReady) begin
                evReceived <= evReceived + 16'd1;
            end
            case (state)
                stIdle: if (SweepStart) begin
                    curDac   <= StartDac;
                    lastDac  <= EndDac;
                    evTarget <= (EventsPerStep == 16'd0) ? 16'd1 : EventsPerStep;
                    state    <= stHeader;
                end
                stHeader: if (queueOk) state <= stMarker;
                stMarker: if (queueOk) state <= stLoad;
                stLoad:   state <= stWaitCfg;
                stWaitCfg: if (ConfigDone) begin
                    evReceived <= '0;
                    pending    <= '0;
                    wordCnt    <= '0;
                    state      <= stAcquire;
                end
                stAcquire: if (pending != 16'd0) begin
                    wordCnt <= '0;
                    state   <= stCopy;
                end
                stCopy: if (queueOk) begin
                    if (!wordLast) begin
                        wordCnt <= wordCnt + 1'b1;
                    end else begin
                        wordCnt <= '0;
                        if (stepComplete) begin
                            StepDone <= 1'b1;
                            if (curDac == lastDac) begin
                                state <= stTail;
                            end else begin
                                curDac <= curDac + 1'b1;
                                state  <= stMarker;
                            end
                        end else if (pending > 16'd1 || EventReady) begin
                            // Next event already complete, keep copying
                            state <= stCopy;
                        end else begin
                            state <= stAcquire;
                        end
                    end
                end
                stTail: if (queueOk) state <= stIdle;
                default: state <= stIdle;
            endcase
        end
    end

endmodule

// ==== rtl/sweepAcqTop.sv ====
`timescale 1ns/100ps
`include "sweep_defs.svh"

module sweepAcqTop (
    input  logic                   Clk,
    input  logic                   reset_n,
    input  logic                   SweepStart,
    input  sweep_pkg::DacCode_t    StartDac,
    input  sweep_pkg::DacCode_t    EndDac,
    input  logic [15:0]            EventsPerStep,
    input  daq_pkg::HitWord_t      HitData,
    input  logic                   HitValid,
    input  logic                   CreditReturn,
    output logic                   ScData,
    output logic                   ScShift,
    output logic                   ScLatch,
    output logic                   AcqEnable,
    output logic [`WORD_WIDTH-1:0] OutData,
    output logic                   OutValid,
    output logic                   OutLast,
    output logic                   StepDone,
    output logic                   SweepBusy
);
    import sweep_pkg::*;
    import daq_pkg::*;

    DacCode_t  dacCode;
    logic      loadDac;
    logic      configDone;
    logic      eventReady;
    logic      hitPush;
    HitWord_t  hitPushData;
    logic      hitPop;
    HitWord_t  hitHead;
    logic      outPush;
    OutEntry_t outPushEntry;
    logic      outPop;
    OutEntry_t outHead;
    logic      outEmpty;
    logic      outFull;

    ////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////
    sweepControl ctrl0 (
        .Clk(Clk), .reset_n(reset_n),
        .SweepStart(SweepStart), .StartDac(StartDac), .EndDac(EndDac),
        .EventsPerStep(EventsPerStep),
        .LoadDac(loadDac), .DacCode(dacCode), .ConfigDone(configDone),
        .AcqEnable(AcqEnable), .EventReady(eventReady),
        .HitPop(hitPop), .HitData(hitHead),
        .OutPush(outPush), .OutEntry(outPushEntry), .OutFull(outFull),
        .StepDone(StepDone), .SweepBusy(SweepBusy)
    );

    scConfigLoader scLoad0 (
        .Clk(Clk), .reset_n(reset_n),
        .LoadDac(loadDac), .DacCode(dacCode),
        .ScData(ScData), .ScShift(ScShift), .ScLatch(ScLatch), .ConfigDone(configDone)
    );

    ////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////
    eventFramer framer0 (
        .Clk(Clk), .reset_n(reset_n),
        .HitData(HitData), .HitValid(HitValid), .AcqEnable(AcqEnable),
        .FifoPush(hitPush), .FifoData(hitPushData), .EventReady(eventReady)
    );

    // Hit FIFO status left open, front end is rate-limited
    syncFifo #(.Payload_t(HitWord_t), .Depth(`HIT_FIFO_DEPTH)) hitFifo0 (
        .Clk(Clk), .reset_n(reset_n),
        .Push(hitPush), .PushData(hitPushData),
        .Pop(hitPop), .PopData(hitHead),
        .Empty(), .Full()
    );

    syncFifo #(.Payload_t(OutEntry_t), .Depth(`OUT_FIFO_DEPTH)) outFifo0 (
        .Clk(Clk), .reset_n(reset_n),
        .Push(outPush), .PushData(outPushEntry),
        .Pop(outPop), .PopData(outHead),
        .Empty(outEmpty), .Full(outFull)
    );

    creditSender sender0 (
        .Clk(Clk), .reset_n(reset_n),
        .QueueData(outHead), .QueueEmpty(outEmpty), .QueuePop(outPop),
        .CreditReturn(CreditReturn),
        .OutData(OutData), .OutValid(OutValid), .OutLast(OutLast)
    );

endmodule

// ==== verification/sweepAcqTb.sv ====
`timescale 1ns/100ps
`include "sweep_defs.svh"

module sweepAcqTb;
    import sweep_pkg::*;

    localparam int ClkPeriod  = 20;
    localparam int DriveDelay = 2;
    localparam int HitGapMax  = 3;
    localparam int NumSweeps  = 3;

    logic                   Clk;
    logic                   reset_n;
    logic                   SweepStart;
    DacCode_t               StartDac;
    DacCode_t               EndDac;
    logic [15:0]            EventsPerStep;
    logic [15:0]            HitData;
    logic                   HitValid;
    logic                   CreditReturn;
    logic                   ScData;
    logic                   ScShift;
    logic                   ScLatch;
    logic                   AcqEnable;
    logic [`WORD_WIDTH-1:0] OutData;
    logic                   OutValid;
    logic                   OutLast;
    logic                   StepDone;
    logic                   SweepBusy;

    integer      seed;
    int          errCount = 0;
    int          checkCount = 0;
    int          testCount = 0;
    int          watchdogCycles = 0;
    int          outValidCount = 0;
    int          creditReturnCount = 0;
    int          creditsOwed = 0;
    int          creditGapMax = 0;
    int          stepDoneCount = 0;
    int          latchCount = 0;
    int          shiftCount = 0;
    logic        tailSeen = 1'b0;
    DacCode_t    scBits;
    DacCode_t    sweepFirstDac;
    logic [15:0] sentWords [$];
    logic [16:0] gotStream [$];

    // Per-sweep settings drawn once at time zero
    DacCode_t    planFirst [NumSweeps];
    int          planSteps [NumSweeps];
    int          planEvents [NumSweeps];
    int          planGap [NumSweeps];

    sweepAcqTop dut0 (
        .Clk(Clk), .reset_n(reset_n),
        .SweepStart(SweepStart), .StartDac(StartDac), .EndDac(EndDac),
        .EventsPerStep(EventsPerStep),
        .HitData(HitData), .HitValid(HitValid), .CreditReturn(CreditReturn),
        .ScData(ScData), .ScShift(ScShift), .ScLatch(ScLatch), .AcqEnable(AcqEnable),
        .OutData(OutData), .OutValid(OutValid), .OutLast(OutLast),
        .StepDone(StepDone), .SweepBusy(SweepBusy)
    );

    initial begin
        Clk = 1'b0;
        forever begin
            #(ClkPeriod / 2) Clk = ~Clk;
        end
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////
    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    function automatic DacCode_t bitReverse(input DacCode_t code);
        DacCode_t rev;
        for (int i = 0; i < `DAC_WIDTH; i++) begin
            rev[i] = code[`DAC_WIDTH-1-i];
        end
        return rev;
    endfunction

    function automatic int pickBelow(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    ////////////////////////////////////////////////////////////
    // Front-end emulator and credit-returning sink
    ////////////////////////////////////////////////////////////
    initial begin : stimulus
        int hitGap;
        int creditGap;
        hitGap    = 0;
        creditGap = 0;
        forever begin
            @(posedge Clk);
            #DriveDelay;
            HitValid = 1'b0;
            // AcqEnable only moves on a clock edge so this word is accepted
            if (AcqEnable && hitGap == 0) begin
                HitValid = 1'b1;
                HitData  = 16'($random(seed));
                sentWords.push_back(HitData);
                hitGap = pickBelow(HitGapMax + 1);
            end else if (hitGap > 0) begin
                hitGap--;
            end
            CreditReturn = 1'b0;
            if (creditsOwed > 0 && creditGap == 0) begin
                CreditReturn = 1'b1;
                creditsOwed--;
                creditGap = pickBelow(creditGapMax + 1);
            end else if (creditGap > 0) begin
                creditGap--;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Output, credit and slow-control monitor
    ////////////////////////////////////////////////////////////
    always @(negedge Clk) begin
        if (reset_n) begin
            if (OutValid) begin
                gotStream.push_back({OutLast, OutData});
                outValidCount++;
                creditsOwed++;
                if (outValidCount > `CREDIT_MAX + creditReturnCount) begin
                    errCount++;
                    $display("Credit overrun: %0d words sent with only %0d credits returned",
                             outValidCount, creditReturnCount);
                end
                if (OutLast) begin
                    tailSeen = 1'b1;
                end
            end
            // A returned credit only frees a word at the next edge
            if (CreditReturn) begin
                creditReturnCount++;
            end
            if (StepDone) begin
                stepDoneCount++;
            end
            if (ScShift) begin
                scBits = {scBits[`DAC_WIDTH-2:0], ScData};
                shiftCount++;
            end
            if (ScLatch) begin
                checkValue("ScShift cycles", shiftCount, `DAC_WIDTH);
                checkValue("ScData", scBits,
                           bitReverse(DacCode_t'(sweepFirstDac + latchCount)));
                latchCount++;
                shiftCount = 0;
            end
        end
    end

    initial begin : watchdog
        wait (watchdogCycles > 0);
        repeat (watchdogCycles) @(posedge Clk);
        $display("Watchdog expired after %0d cycles, a sweep never finished", watchdogCycles);
        $display("RESULT: FAIL");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // One sweep against the stream model
    ////////////////////////////////////////////////////////////
    task automatic runSweep(input string name, input DacCode_t firstDac, input int steps,
                            input int events, input int gap);
        int          errBefore;
        int          n;
        logic [16:0] expStream [$];
        errBefore = errCount;
        sentWords.delete();
        gotStream.delete();
        tailSeen      = 1'b0;
        stepDoneCount = 0;
        latchCount    = 0;
        shiftCount    = 0;
        sweepFirstDac = firstDac;
        creditGapMax  = gap;
        @(posedge Clk);
        #DriveDelay;
        SweepStart    = 1'b1;
        StartDac      = firstDac;
        EndDac        = DacCode_t'(firstDac + steps - 1);
        EventsPerStep = 16'(events);
        @(posedge Clk);
        #DriveDelay;
        SweepStart = 1'b0;
        checkValue("SweepBusy", SweepBusy, 1'b1);
        wait (tailSeen);
        checkValue("SweepBusy", SweepBusy, 1'b0);
        while (creditsOwed != 0) begin
            @(posedge Clk);
        end
        repeat (4) @(posedge Clk);

        // Header, then a marker and the words sent for every code, then the tail
        checkValue("hit words sent", sentWords.size(), steps * events * `WORDS_PER_EVENT);
        expStream.push_back({1'b0, `HEADER_WORD});
        for (int s = 0; s < steps; s++) begin
            expStream.push_back({1'b0, `STEP_TAG, 2'b00, DacCode_t'(firstDac + s)});
            for (int w = 0; w < events * `WORDS_PER_EVENT; w++) begin
                if (sentWords.size() > 0) begin
                    expStream.push_back({1'b0, sentWords.pop_front()});
                end
            end
        end
        expStream.push_back({1'b1, `TAIL_WORD});

        checkValue("stream length", gotStream.size(), expStream.size());
        n = (gotStream.size() < expStream.size()) ? gotStream.size() : expStream.size();
        for (int i = 0; i < n; i++) begin
            checkValue("OutData", gotStream[i][15:0], expStream[i][15:0]);
            checkValue("OutLast", gotStream[i][16], expStream[i][16]);
        end
        checkValue("StepDone pulses", stepDoneCount, steps);
        checkValue("ScLatch pulses", latchCount, steps);
        testCount++;
        $display("Test %0d %s: %0d codes from 0x%0h, %0d events/step, %0d words, %0d errors",
                 testCount, name, steps, firstDac, events, gotStream.size(),
                 errCount - errBefore);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin : mainFlow
        int errBefore;
        int wordCost;
        int limit;
        seed          = 47050;
        reset_n       = 1'b0;
        SweepStart    = 1'b0;
        StartDac      = '0;
        EndDac        = '0;
        EventsPerStep = '0;
        HitData       = '0;
        HitValid      = 1'b0;
        CreditReturn  = 1'b0;
        scBits        = '0;
        sweepFirstDac = '0;
        limit         = 0;

        // Normal sweep, long credit delays, single code
        planSteps[0] = 2 + pickBelow(3);
        planGap[0]   = 3;
        planSteps[1] = 2;
        planGap[1]   = 30 + pickBelow(11);
        planSteps[2] = 1;
        planGap[2]   = 3;
        for (int i = 0; i < NumSweeps; i++) begin
            planEvents[i] = 1 + pickBelow(3);
            planFirst[i]  = DacCode_t'(pickBelow(1025 - planSteps[i]));
            wordCost = HitGapMax + 1 + planGap[i] + 3;
            limit += 2 * (100 + planSteps[i] * (`DAC_WIDTH + `SETTLE_CYCLES + 20
                     + planEvents[i] * `WORDS_PER_EVENT * wordCost));
        end
        watchdogCycles = limit + 200;

        repeat (3) @(posedge Clk);
        #DriveDelay;
        reset_n = 1'b1;

        // Quiet outputs after reset and nothing sent while idle
        errBefore = errCount;
        @(negedge Clk);
        checkValue("OutValid", OutValid, 1'b0);
        checkValue("SweepBusy", SweepBusy, 1'b0);
        checkValue("AcqEnable", AcqEnable, 1'b0);
        checkValue("ScShift", ScShift, 1'b0);
        checkValue("ScLatch", ScLatch, 1'b0);
        repeat (10) @(posedge Clk);
        checkValue("words before SweepStart", gotStream.size(), 0);
        testCount++;
        $display("Test %0d reset and idle: %0d errors", testCount, errCount - errBefore);

        runSweep("random sweep", planFirst[0], planSteps[0], planEvents[0], planGap[0]);
        runSweep("slow credits", planFirst[1], planSteps[1], planEvents[1], planGap[1]);
        runSweep("single code", planFirst[2], planSteps[2], planEvents[2], planGap[2]);

        $display("Tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, errCount);
        if (errCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== sweepAcqTop.f ====
+incdir+rtl
rtl/sweep_pkg.sv
rtl/daq_pkg.sv
rtl/syncFifo.sv
rtl/eventFramer.sv
rtl/scConfigLoader.sv
rtl/creditSender.sv
rtl/sweepControl.sv
rtl/sweepAcqTop.sv
verification/sweepAcqTb.sv

// ==== Makefile ====
# Verilator build and run for the sweep acquisition testbench

VERILATOR ?= verilator
TOP       ?= sweepAcqTb
FILELIST  ?= sweepAcqTop.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
FAIL_MSG  ?= RESULT: FAIL

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS FAIL_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "No result found in $(LOG)"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
